/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing -Wno-fatal -j 0
TOP      = switch_tb
FILELIST = list.f

OBJ_DIR  = obj_dir
SIM_BIN  = $(OBJ_DIR)/V$(TOP)
SOURCES  = $(wildcard design/*.sv) $(wildcard testbench/*.sv) $(wildcard testbench/*.svh)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx "STATUS: PASS"

clean:
	rm -rf $(OBJ_DIR)

/* design/buffer_arbiter.sv */
`timescale 1ns/1ps

module buffer_arbiter
    import switch_cfg_pkg::*;
    import switch_bus_pkg::*;
(
    input  logic                          internal_clk,
    input  logic                          reset,
    input  ingress_req_t [PORT_COUNT-1:0] requests,
    output port_mask_t                    write_grant,
    input  port_mask_t                    read_req,
    input  port_mask_t                    qos_control,
    output port_mask_t                    read_grant,
    output buf_write_t                    buf_write,
    output buf_read_t                     buf_read
);

    // first set bit of mask at or after start, wrapping around.
    function automatic port_id_t rr_pick(input port_mask_t mask, input port_id_t start);
        port_id_t idx;
        port_id_t pick;
        pick = start;
        for (int k = PORT_COUNT - 1; k >= 0; k--) begin
            idx = start + port_id_t'(k);
            if (mask[idx])
                pick = idx;
        end
        return pick;
    endfunction

    port_mask_t wr_req;
    port_mask_t rd_class;    // qos requesters if any, else all of them.
    port_id_t   wr_next;
    port_id_t   rd_next;
    port_id_t   wr_sel;
    port_id_t   rd_sel;
    logic       locked;
    port_id_t   lock_port;

    always_comb begin
        for (int i = 0; i < PORT_COUNT; i++)
            wr_req[i] = requests[i].req;
    end

    assign wr_sel   = locked ? lock_port : rr_pick(wr_req, wr_next);
    assign rd_class = |(read_req & qos_control) ? (read_req & qos_control) : read_req;
    assign rd_sel   = rr_pick(rd_class, rd_next);

    always_comb begin
        write_grant         = '0;
        write_grant[wr_sel] = wr_req[wr_sel]; // a locked owner may idle.
        read_grant          = '0;
        read_grant[rd_sel]  = rd_class[rd_sel];

        buf_write.en    = |write_grant;
        buf_write.dest  = requests[wr_sel].dest;
        buf_write.word  = requests[wr_sel].word;
        buf_read.en     = |read_grant;
        buf_read.queue_id = rd_sel;          // egress n drains queue n.
    end

    always_ff @(posedge internal_clk) begin
        if (reset) begin
            locked    <= 1'b0;
            lock_port <= '0;
            wr_next   <= '0;
            rd_next   <= '0;
        end else begin
            if (buf_write.en) begin
                wr_next <= wr_sel + 1'b1;
                if (buf_write.word.eop) begin
                    locked <= 1'b0;
                end else if (buf_write.word.sop) begin
                    locked    <= 1'b1;  // keep this packet contiguous.
                    lock_port <= wr_sel;
                end
            end
            if (buf_read.en)
                rd_next <= rd_sel + 1'b1;
        end
    end

endmodule

/* design/egress_port.sv */
`timescale 1ns/1ps

module egress_port
    import switch_cfg_pkg::*;
    import switch_bus_pkg::*;
#(
    parameter int PORT_NUMBER = 0
)
(
    input  logic        internal_clk,
    input  logic        reset,
    input  logic        queue_empty,
    input  logic        ready,
    input  logic        read_grant,
    input  frame_word_t read_word,
    input  logic        read_valid,
    input  port_id_t    read_port,
    output logic        read_req,
    output logic        rd_sop,
    output logic        rd_eop,
    output logic        rd_vld,
    output word_t       rd_data
);

    logic in_flight;    // granted, word not yet back from the buffer.
    logic own_word;

    assign own_word = read_valid && (read_port == port_id_t'(PORT_NUMBER));

    // one outstanding read at a time, and none while the sink stalls.
    assign read_req = !queue_empty && ready && !in_flight;

    always_ff @(posedge internal_clk) begin
        if (reset) begin
            in_flight <= 1'b0;
            rd_vld    <= 1'b0;
            rd_sop    <= 1'b0;
            rd_eop    <= 1'b0;
        end else begin
            if (read_grant)
                in_flight <= 1'b1;
            else if (own_word)
                in_flight <= 1'b0;

            // a word already in flight is delivered even if ready dropped.
            rd_vld <= own_word;
            rd_sop <= own_word && read_word.sop;
            rd_eop <= own_word && read_word.eop;
        end
    end

    always_ff @(posedge internal_clk) begin
        if (own_word)
            rd_data <= read_word.data;
    end

endmodule

/* design/ingress_port.sv */
`timescale 1ns/1ps

module ingress_port
    import switch_cfg_pkg::*;
    import switch_bus_pkg::*;
(
    input  logic         internal_clk,
    input  logic         reset,
    input  logic         wr_sop,
    input  logic         wr_eop,
    input  logic         wr_vld,
    input  word_t        wr_data,
    input  port_mask_t   queue_full,
    input  logic         write_grant,
    output ingress_req_t request,
    output logic         error
);

    typedef logic [$clog2(STAGE_DEPTH)-1:0] stage_ptr_t;
    typedef logic [$clog2(STAGE_DEPTH):0]   stage_level_t;

    frame_word_t  stage_word [STAGE_DEPTH];
    port_id_t     stage_dest [STAGE_DEPTH];
    stage_ptr_t   wr_ptr;
    stage_ptr_t   rd_ptr;
    stage_level_t level;

    logic         in_packet;   // an accepted sop has not seen its eop yet.
    port_id_t     cur_dest;
    port_id_t     word_dest;
    logic         legal_word;
    logic         stage_full;
    logic         stage_empty;
    logic         push;
    logic         pop;

    assign stage_full  = (level == stage_level_t'(STAGE_DEPTH));
    assign stage_empty = (level == '0);

    // destination rides in the low bits of the sop word.
    assign word_dest  = wr_sop ? wr_data[$bits(port_id_t)-1:0] : cur_dest;
    assign legal_word = wr_sop || in_packet;
    assign push       = wr_vld && legal_word && !stage_full;
    assign pop        = request.req && write_grant;

    always_comb begin
        request.req  = !stage_empty && !queue_full[stage_dest[rd_ptr]]; // hold while queue full.
        request.dest = stage_dest[rd_ptr];
        request.word = stage_word[rd_ptr];
    end

    always_ff @(posedge internal_clk) begin
        if (reset) begin
            in_packet <= 1'b0;
            cur_dest  <= '0;
            error     <= 1'b0;
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            level     <= '0;
        end else begin
            error <= wr_vld && (!legal_word || stage_full); // framing or overflow.
            if (wr_vld && legal_word) begin
                in_packet <= !wr_eop;
                if (wr_sop)
                    cur_dest <= word_dest;
            end
            if (push)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            case ({push, pop})
                2'b10:   level <= level + 1'b1;
                2'b01:   level <= level - 1'b1;
                default: ;
            endcase
        end
    end

    always_ff @(posedge internal_clk) begin
        if (push) begin
            stage_word[wr_ptr] <= '{sop: wr_sop, eop: wr_eop, data: wr_data};
            stage_dest[wr_ptr] <= word_dest;
        end
    end

endmodule

/* design/packet_buffer.sv */
`timescale 1ns/1ps

module packet_buffer
    import switch_cfg_pkg::*;
    import switch_bus_pkg::*;
(
    input  logic        internal_clk,
    input  logic        reset,
    input  buf_write_t  buf_write,
    input  buf_read_t   buf_read,
    output frame_word_t read_word,
    output logic        read_valid,
    output port_id_t    read_port,
    output port_mask_t  queue_full,
    output port_mask_t  queue_empty,
    output logic        full,
    output logic        almost_full
);

    typedef logic [$clog2(QUEUE_DEPTH):0] queue_count_t;
    typedef logic [$bits(port_id_t)+$bits(queue_ptr_t)-1:0] mem_addr_t;

    // queue q owns the slots q*QUEUE_DEPTH up to q*QUEUE_DEPTH+QUEUE_DEPTH-1.
    frame_word_t  mem [PORT_COUNT*QUEUE_DEPTH];

    queue_ptr_t   head  [PORT_COUNT];
    queue_ptr_t   tail  [PORT_COUNT];
    queue_count_t count [PORT_COUNT];

    port_mask_t   queue_high;
    port_mask_t   wr_hit;
    port_mask_t   rd_hit;
    mem_addr_t    wr_addr;
    mem_addr_t    rd_addr;
    logic         do_write;
    logic         do_read;

    always_comb begin
        for (int q = 0; q < PORT_COUNT; q++) begin
            queue_full[q]  = (count[q] == queue_count_t'(QUEUE_DEPTH));
            queue_empty[q] = (count[q] == '0);
            queue_high[q]  = (count[q] >= queue_count_t'(ALMOST_FULL_LEVEL));
        end
    end

    assign full        = |queue_full;
    assign almost_full = |queue_high;

    // writes to a full queue and reads of an empty one are ignored.
    assign do_write = buf_write.en && !queue_full[buf_write.dest];
    assign do_read  = buf_read.en && !queue_empty[buf_read.queue_id];

    assign wr_addr = {buf_write.dest, tail[buf_write.dest]};
    assign rd_addr = {buf_read.queue_id, head[buf_read.queue_id]};

    assign wr_hit = do_write ? port_mask_t'(1) << buf_write.dest : '0;
    assign rd_hit = do_read ? port_mask_t'(1) << buf_read.queue_id : '0;

    always_ff @(posedge internal_clk) begin
        if (do_write)
            mem[wr_addr] <= buf_write.word;
        if (do_read)
            read_word <= mem[rd_addr]; // word shows the cycle after the grant.
    end

    always_ff @(posedge internal_clk) begin
        if (reset) begin
            read_valid <= 1'b0;
            read_port  <= '0;
            for (int q = 0; q < PORT_COUNT; q++) begin
                head[q]  <= '0;
                tail[q]  <= '0;
                count[q] <= '0;
            end
        end else begin
            read_valid <= do_read;
            if (do_read)
                read_port <= buf_read.queue_id;
            for (int q = 0; q < PORT_COUNT; q++) begin
                if (wr_hit[q])
                    tail[q] <= tail[q] + 1'b1;
                if (rd_hit[q])
                    head[q] <= head[q] + 1'b1;
                case ({wr_hit[q], rd_hit[q]})
                    2'b10:   count[q] <= count[q] + 1'b1;
                    2'b01:   count[q] <= count[q] - 1'b1;
                    default: ;  // none, or one in and one out.
                endcase
            end
        end
    end

endmodule

/* design/switch_bus_pkg.sv */
package switch_bus_pkg;

    import switch_cfg_pkg::*;

    // one word of a packet with its framing bits.
    typedef struct packed {
        logic  sop;
        logic  eop;
        word_t data;
    } frame_word_t;

    typedef struct packed {
        logic        en;
        port_id_t    dest;    // queue the word is appended to.
        frame_word_t word;
    } buf_write_t;

    typedef struct packed {
        logic     en;
        port_id_t queue_id;   // queue popped by this read.
    } buf_read_t;

    // head of an ingress staging fifo as offered to the arbiter.
    typedef struct packed {
        logic        req;
        port_id_t    dest;
        frame_word_t word;
    } ingress_req_t;

endpackage

/* design/switch_cfg_pkg.sv */
package switch_cfg_pkg;

    // switch geometry.
    localparam int PORT_COUNT  = 4;
    localparam int DATA_WIDTH  = 16;

    localparam int QUEUE_DEPTH = 16; // entries per destination queue.
    localparam int STAGE_DEPTH = 4;  // ingress staging fifo.

    // occupancy of one queue that raises almost_full.
    localparam int ALMOST_FULL_LEVEL = 12;

    // port number, also used as the destination queue id.
    typedef logic [$clog2(PORT_COUNT)-1:0] port_id_t;

    typedef logic [DATA_WIDTH-1:0] word_t;

    // slot index inside one destination queue.
    typedef logic [$clog2(QUEUE_DEPTH)-1:0] queue_ptr_t;

    typedef logic [PORT_COUNT-1:0] port_mask_t; // one bit per port.

endpackage

/* design/switch_top.sv */
`timescale 1ns/1ps

module switch_top
    import switch_cfg_pkg::*;
    import switch_bus_pkg::*;
(
    input  logic                   internal_clk,
    input  logic                   reset,

    input  port_mask_t             wr_sop,
    input  port_mask_t             wr_eop,
    input  port_mask_t             wr_vld,
    input  word_t [PORT_COUNT-1:0] wr_data,

    output port_mask_t             rd_sop,
    output port_mask_t             rd_eop,
    output port_mask_t             rd_vld,
    output word_t [PORT_COUNT-1:0] rd_data,

    input  port_mask_t             qos_control,
    input  port_mask_t             ready,
    output port_mask_t             error,
    output logic                   full,
    output logic                   almost_full
);

    ingress_req_t [PORT_COUNT-1:0] requests;
    port_mask_t                    write_grant;
    port_mask_t                    read_req;
    port_mask_t                    read_grant;
    port_mask_t                    queue_full;
    port_mask_t                    queue_empty;
    buf_write_t                    buf_write;
    buf_read_t                     buf_read;
    frame_word_t                   read_word;   // shared return path.
    logic                          read_valid;
    port_id_t                      read_port;

    for (genvar i = 0; i < PORT_COUNT; i++) begin : layout
        ingress_port ingress_port (
            .internal_clk (internal_clk),
            .reset        (reset),
            .wr_sop       (wr_sop[i]),
            .wr_eop       (wr_eop[i]),
            .wr_vld       (wr_vld[i]),
            .wr_data      (wr_data[i]),
            .queue_full   (queue_full),
            .write_grant  (write_grant[i]),
            .request      (requests[i]),
            .error        (error[i])
        );

        egress_port #(.PORT_NUMBER(i)) egress_port (
            .internal_clk (internal_clk),
            .reset        (reset),
            .queue_empty  (queue_empty[i]),
            .ready        (ready[i]),
            .read_grant   (read_grant[i]),
            .read_word    (read_word),
            .read_valid   (read_valid),
            .read_port    (read_port),
            .read_req     (read_req[i]),
            .rd_sop       (rd_sop[i]),
            .rd_eop       (rd_eop[i]),
            .rd_vld       (rd_vld[i]),
            .rd_data      (rd_data[i])
        );
    end

    buffer_arbiter buffer_arbiter (
        .internal_clk (internal_clk),
        .reset        (reset),
        .requests     (requests),
        .write_grant  (write_grant),
        .read_req     (read_req),
        .qos_control  (qos_control),
        .read_grant   (read_grant),
        .buf_write    (buf_write),
        .buf_read     (buf_read)
    );

    packet_buffer packet_buffer (
        .internal_clk (internal_clk),
        .reset        (reset),
        .buf_write    (buf_write),
        .buf_read     (buf_read),
        .read_word    (read_word),
        .read_valid   (read_valid),
        .read_port    (read_port),
        .queue_full   (queue_full),
        .queue_empty  (queue_empty),
        .full         (full),
        .almost_full  (almost_full)
    );

endmodule

/* list.f */
+incdir+testbench
design/switch_cfg_pkg.sv
design/switch_bus_pkg.sv
design/ingress_port.sv
design/buffer_arbiter.sv
design/packet_buffer.sv
design/egress_port.sv
design/switch_top.sv
testbench/switch_tb.sv

/* testbench/switch_tb_tests.svh */
`ifndef SWITCH_TB_TESTS_SVH
`define SWITCH_TB_TESTS_SVH

task automatic reset_state_test();
    begin_test("reset_state");
    check_flags("rd_vld", '0, rd_vld);
    check_flags("rd_sop", '0, rd_sop);
    check_flags("rd_eop", '0, rd_eop);
    check_flags("error", '0, error);
    check_bit("full", 1'b0, full);
    check_bit("almost_full", 1'b0, almost_full);
    end_test();
endtask

task automatic single_path_test();
    begin_test("single_path");
    send_and_release(0, 2, 5);
    wait_drain(100);
    end_test();
endtask

// inputs start one cycle apart and two of them share each busy output.
// the packet lock keeps each output's packets whole and in start order.
task automatic all_to_all_test();
    int len;
    begin_test("all_to_all");
    for (int r = 0; r < 2 * PORT_COUNT; r++) begin
        len = 2 + (r % 3);   // never more than the staging depth.
        fork
            send_and_release(0, port_id_t'(r), len);
            begin
                @(negedge internal_clk);
                send_and_release(1, port_id_t'(r), len);
            end
            begin
                repeat (2) @(negedge internal_clk);
                send_and_release(2, port_id_t'(r + 2), len);
            end
            begin
                repeat (3) @(negedge internal_clk);
                send_and_release(3, port_id_t'(r + 2), len);
            end
        join
        wait_drain(200);
    end
    end_test();
endtask

task automatic back_pressure_test();
    begin_test("back_pressure");
    @(negedge internal_clk);
    ready = 4'b1101;
    for (int n = 0; n < 3; n++)
        send_packet(0, 1, 4);
    release_port(0);
    wait_for(WATCH_ALMOST_FULL, 0, 20); // 12 words in queue 1.
    check_bit("full at 12 entries", 1'b0, full);
    send_and_release(0, 1, 4);
    wait_for(WATCH_FULL, 0, 20);
    check_bit("almost_full at 16 entries", 1'b1, almost_full);
    check_flags("rd_vld while held", '0, rd_vld);
    @(negedge internal_clk);
    ready = 4'b1111;
    wait_drain(200);
    check_bit("full after drain", 1'b0, full);
    check_bit("almost_full after drain", 1'b0, almost_full);
    end_test();
endtask

task automatic ingress_error_test();
    word_t extra_word;
    begin_test("ingress_error");
    @(negedge internal_clk);
    ready = 4'b1101;
    for (int n = 0; n < 4; n++)
        send_packet(0, 1, 4);
    release_port(0);
    wait_for(WATCH_FULL, 0, 40);
    // four words fill the stage, the fifth is dropped.
    send_packet(2, 1, 4);
    extra_word = word_t'($urandom);
    extra_word[$bits(port_id_t)-1:0] = port_id_t'(1);
    drive_word(2, 1'b1, 1'b1, extra_word);
    release_port(2);
    wait_for(WATCH_ERROR, 2, 5);
    check_flags("error on overflow", 4'b0100, error);
    @(negedge internal_clk);
    check_flags("error after overflow pulse", '0, error);
    drive_word(3, 1'b0, 1'b0, word_t'($urandom)); // no open packet on input 3.
    release_port(3);
    wait_for(WATCH_ERROR, 3, 5);
    check_flags("error on framing", 4'b1000, error);
    @(negedge internal_clk);
    ready = 4'b1111;
    wait_drain(300);
    check_flags("error after drain", '0, error);
    end_test();
endtask

task automatic qos_priority_test();
    int   cycles;
    logic returned;
    begin_test("qos_priority");
    send_and_release(2, 3, 2); // a last read from queue 3 turns the read rotation to output 0.
    wait_drain(100);
    @(negedge internal_clk);
    ready = 4'b0110;
    fork
        send_and_release(0, 0, 3);
        send_and_release(1, 3, 3);
    join
    wait_for(WATCH_QUEUE, 0, 20);
    wait_for(WATCH_QUEUE, 3, 20);
    @(negedge internal_clk);
    qos_control = 4'b1000;
    ready       = 4'b1111;
    // the buffer returns the word one cycle after the grant.
    cycles   = 0;
    returned = 1'b0;
    while (!returned && cycles < 10) begin
        @(negedge internal_clk);
        returned = dut.read_valid;
        cycles++;
    end
    if (!returned) begin
        fail_count++;
        $display("timeout in %s: no read was granted within 10 cycles", current_test);
    end else begin
        check_bit("first read goes to queue 3", 1'b1, dut.read_port == port_id_t'(3));
        check_bit("rd_vld[3] one cycle after grant", 1'b0, rd_vld[3]);
        @(negedge internal_clk);
        check_bit("rd_vld[3] two cycles after grant", 1'b1, rd_vld[3]);
        check_bit("rd_vld[0] behind output 3", 1'b0, rd_vld[0]);
    end
    wait_drain(100);
    qos_control = '0;
    end_test();
endtask

`endif

/* testbench/switch_tb.sv */
`timescale 1ns/1ps

module switch_tb
    import switch_cfg_pkg::*;
    import switch_bus_pkg::*;
();

    typedef enum {WATCH_FULL, WATCH_ALMOST_FULL, WATCH_ERROR, WATCH_QUEUE} watch_t;

    logic                   internal_clk;
    logic                   reset;
    port_mask_t             wr_sop;
    port_mask_t             wr_eop;
    port_mask_t             wr_vld;
    word_t [PORT_COUNT-1:0] wr_data;
    port_mask_t             rd_sop;
    port_mask_t             rd_eop;
    port_mask_t             rd_vld;
    word_t [PORT_COUNT-1:0] rd_data;
    port_mask_t             qos_control;
    port_mask_t             ready;
    port_mask_t             error;
    logic                   full;
    logic                   almost_full;

    frame_word_t exp_q [PORT_COUNT][$]; // words each output still owes, in order.
    string       current_test;
    int          fail_count;
    int          check_count;
    int          test_count;
    int          test_fails;

    switch_top dut (
        .internal_clk (internal_clk),
        .reset        (reset),
        .wr_sop       (wr_sop),
        .wr_eop       (wr_eop),
        .wr_vld       (wr_vld),
        .wr_data      (wr_data),
        .rd_sop       (rd_sop),
        .rd_eop       (rd_eop),
        .rd_vld       (rd_vld),
        .rd_data      (rd_data),
        .qos_control  (qos_control),
        .ready        (ready),
        .error        (error),
        .full         (full),
        .almost_full  (almost_full)
    );

    initial begin
        internal_clk = 1'b0;
        forever #10 internal_clk = ~internal_clk;
    end

    task automatic check_word(input string what, input word_t expected, input word_t actual);
        check_count++;
        if (actual !== expected) begin
            fail_count++;
            $display("FAILED %s %s: expected %h, actual %h", current_test, what, expected, actual);
        end
    endtask

    task automatic check_flags(input string what, input port_mask_t expected,
                               input port_mask_t actual);
        check_count++;
        if (actual !== expected) begin
            fail_count++;
            $display("FAILED %s %s: expected %b, actual %b", current_test, what, expected, actual);
        end
    endtask

    task automatic check_bit(input string what, input logic expected, input logic actual);
        check_count++;
        if (actual !== expected) begin
            fail_count++;
            $display("FAILED %s %s: expected %b, actual %b", current_test, what, expected, actual);
        end
    endtask

    // the scoreboard looks at outputs half a cycle after the edge that moved them.
    always @(negedge internal_clk) begin
        frame_word_t exp_word;
        if (!reset) begin
            for (int p = 0; p < PORT_COUNT; p++) begin
                if (rd_vld[p] && exp_q[p].size() == 0) begin
                    fail_count++;
                    $display("error in %s: output %0d delivered %h with nothing expected",
                             current_test, p, rd_data[p]);
                end else if (rd_vld[p]) begin
                    exp_word = exp_q[p].pop_front();
                    check_word($sformatf("output %0d data", p), exp_word.data, rd_data[p]);
                    check_bit($sformatf("output %0d sop", p), exp_word.sop, rd_sop[p]);
                    check_bit($sformatf("output %0d eop", p), exp_word.eop, rd_eop[p]);
                end
            end
        end
    end

    function automatic logic watched_level(input watch_t what, input port_id_t port);
        case (what)
            WATCH_FULL:        return full;
            WATCH_ALMOST_FULL: return almost_full;
            WATCH_ERROR:       return error[port];
            default:           return !dut.queue_empty[port]; // queue holds a word.
        endcase
    endfunction

    task automatic wait_for(input watch_t what, input port_id_t port, input int limit);
        int cycles;
        cycles = 0;
        while (!watched_level(what, port) && cycles < limit) begin
            @(negedge internal_clk);
            cycles++;
        end
        if (!watched_level(what, port)) begin
            fail_count++;
            $display("timeout in %s: %s on port %0d did not rise within %0d cycles",
                     current_test, what.name(), port, limit);
        end
    endtask

    function automatic int queued_words();
        int total;
        total = 0;
        for (int p = 0; p < PORT_COUNT; p++)
            total += exp_q[p].size();
        return total;
    endfunction

    task automatic wait_drain(input int limit);
        int cycles;
        cycles = 0;
        while (queued_words() != 0 && cycles < limit) begin
            @(negedge internal_clk);
            cycles++;
        end
        if (queued_words() != 0) begin
            fail_count++;
            $display("timeout in %s: %0d expected words never came out",
                     current_test, queued_words());
            for (int p = 0; p < PORT_COUNT; p++)
                exp_q[p].delete();
        end
    endtask

    task automatic drive_word(input port_id_t src, input logic sop, input logic eop,
                              input word_t data);
        @(negedge internal_clk);
        wr_vld[src]  = 1'b1;
        wr_sop[src]  = sop;
        wr_eop[src]  = eop;
        wr_data[src] = data;
    endtask

    task automatic release_port(input port_id_t src);
        @(negedge internal_clk);
        wr_vld[src] = 1'b0;
        wr_sop[src] = 1'b0;
        wr_eop[src] = 1'b0;
    endtask

    // the whole packet is expected before its first word is driven.
    // words go out back to back; the caller releases the port.
    task automatic send_packet(input port_id_t src, input port_id_t dest, input int len);
        frame_word_t fw;
        frame_word_t pkt [$];
        for (int k = 0; k < len; k++) begin
            fw.sop  = (k == 0);
            fw.eop  = (k == len - 1);
            fw.data = word_t'($urandom);
            if (k == 0)
                fw.data[$bits(port_id_t)-1:0] = dest; // destination rides in the sop word.
            pkt.push_back(fw);
            exp_q[dest].push_back(fw);
        end
        foreach (pkt[k])
            drive_word(src, pkt[k].sop, pkt[k].eop, pkt[k].data);
    endtask

    task automatic send_and_release(input port_id_t src, input port_id_t dest, input int len);
        send_packet(src, dest, len);
        release_port(src);
    endtask

    task automatic begin_test(input string name);
        current_test = name;
        test_fails   = fail_count;
        test_count++;
    endtask

    task automatic end_test();
        if (fail_count == test_fails)
            $display("%s: passed", current_test);
        else
            $display("%s: %0d failures", current_test, fail_count - test_fails);
    endtask

    `include "switch_tb_tests.svh"

    initial begin
        void'($urandom(32'h4f67));
        reset        = 1'b1;
        wr_sop       = '0;
        wr_eop       = '0;
        wr_vld       = '0;
        wr_data      = '0;
        qos_control  = '0;
        ready        = '1;
        fail_count   = 0;
        check_count  = 0;
        test_count   = 0;
        test_fails   = 0;
        current_test = "reset";
        repeat (2) @(negedge internal_clk);
        reset = 1'b0;

        reset_state_test();
        single_path_test();
        all_to_all_test();
        back_pressure_test();
        ingress_error_test();
        qos_priority_test();

        $display("tests: %0d, checks: %0d, failures: %0d", test_count, check_count, fail_count);
        if (fail_count == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

endmodule
